/* rv_ex.f */
+incdir+rtl
rtl/rv_ex_pkg.sv
rtl/reg_file.sv
rtl/id_decode.sv
rtl/pipe_fifo.sv
rtl/ex_alu.sv
rtl/rv_ex_top.sv
verification/rv_ex_props.sv
verification/rv_ex_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_ex_tb -Mdir "$BUILD_DIR" -f rv_ex.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vrv_ex_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
  echo "Simulation reported errors, see $LOG"
  exit 1
fi

echo "Simulation completed without errors"
exit 0

/* verification/rv_ex_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module rv_ex_tb;
  import rv_ex_pkg::*;

  localparam int TIMEOUT = 200;
  localparam bit MUL_ON  = `RV_MUL_ENABLE;

  logic    clk;
  logic    reset_i;
  logic    instr_valid_i;
  xword_t  instr_i;
  xword_t  pc_i;
  logic    instr_ready_o;
  logic    res_valid_o;
  ex_res_t res_o;
  logic    res_ready_i;

  xword_t  model_regs [`RV_NREGS];  // Architectural state in program order
  ex_res_t exp_q [$];
  ex_res_t got_q [$];
  xword_t  next_pc;
  int      errors;
  int      timeouts;
  int      n_results;
  int      n_sent;
  bit      bp_mode;  // Hold res_ready_i low for hold_len cycles, then toggle it
  int      hold_len;
  int      held;

  rv_ex_top UUT (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .res_valid_o   (res_valid_o),
    .res_o         (res_o),
    .res_ready_i   (res_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic xword_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input reg_idx_t rd, input reg_idx_t rs1,
                                   input reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic xword_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                   input reg_idx_t rd, input reg_idx_t rs1);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic xword_t enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                   input reg_idx_t rd);
    return {imm, rd, opc};
  endfunction

  function automatic xword_t enc_jal(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // ISA level result of one instruction against the model registers
  function automatic ex_res_t ref_exec(input xword_t instr, input xword_t pc);
    ex_res_t     r;
    xword_t      a;
    xword_t      b;
    logic [2:0]  f3;
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    f3 = instr[14:12];
    a = model_regs[instr[19:15]];
    b = instr[5] ? model_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    r.pc = pc;
    r.rd = instr[11:7];
    r.data = '0;
    r.illegal = 1'b0;
    case (instr[6:0])
      7'b0110011, 7'b0010011: begin
        if (instr[5] && instr[31:25] == 7'h01) begin
          // Extending each factor to 64 bits sets its signedness
          ext_a = (f3[1:0] == 2'd3) ? {32'b0, a} : {{32{a[31]}}, a};
          ext_b = (f3[1:0] <= 2'd1) ? {{32{b[31]}}, b} : {32'b0, b};
          prod = ext_a * ext_b;
          r.data = (f3[1:0] == 2'd0) ? prod[31:0] : prod[63:32];
          r.illegal = !MUL_ON;
        end else begin
          case (f3)
            3'd0: r.data = (instr[5] && instr[30]) ? a - b : a + b;
            3'd1: r.data = a << b[4:0];
            3'd2: r.data = {31'b0, $signed(a) < $signed(b)};
            3'd3: r.data = {31'b0, a < b};
            3'd4: r.data = a ^ b;
            3'd5: begin
              if (instr[30]) begin
                r.data = $signed(a) >>> b[4:0];
              end else begin
                r.data = a >> b[4:0];
              end
            end
            3'd6: r.data = a | b;
            3'd7: r.data = a & b;
          endcase
        end
      end
      7'b0110111: r.data = {instr[31:12], 12'b0};
      7'b0010111: r.data = pc + {instr[31:12], 12'b0};
      7'b1101111: r.data = pc + 32'd4;
      default:    r.illegal = 1'b1;
    endcase
    return r;
  endfunction

  task automatic check_res(input ex_res_t got, input ex_res_t exp);
    // Data of an illegal instruction carries no meaning
    if (got.pc !== exp.pc || got.rd !== exp.rd || got.illegal !== exp.illegal ||
        (!exp.illegal && got.data !== exp.data)) begin
      errors++;
      $display("[FAIL] %0t: got pc %h rd %0d data %h illegal %b", $time,
               got.pc, got.rd, got.data, got.illegal);
      $display("[FAIL] %0t: expected pc %h rd %0d data %h illegal %b", $time,
               exp.pc, exp.rd, exp.data, exp.illegal);
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t: %0d results counted, expected %0d", $time, got, exp);
    end
  endtask

  task automatic send_instr(input xword_t instr);
    ex_res_t exp;
    int      waited;
    exp = ref_exec(instr, next_pc);
    if (!exp.illegal && exp.rd != '0) begin
      model_regs[exp.rd] = exp.data;
    end
    exp_q.push_back(exp);
    n_sent++;
    instr_valid_i = 1'b1;
    instr_i = instr;
    pc_i = next_pc;
    waited = 0;
    @(negedge clk);
    while (!instr_ready_o && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    if (!instr_ready_o) begin
      timeouts++;
      $display("Timeout: instruction %h at pc %h was never accepted", instr, next_pc);
    end
    @(posedge clk);
    #0.5;
    instr_valid_i = 1'b0;
    next_pc = next_pc + 32'd4;
  endtask

  // Waits until every outstanding result is in, then checks them in order
  task automatic collect_results();
    ex_res_t got;
    int      waited;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < TIMEOUT) begin
      @(posedge clk);
      #0.5;
      waited++;
    end
    if (got_q.size() < exp_q.size()) begin
      timeouts++;
      $display("Timeout: only %0d of %0d results arrived", got_q.size(), exp_q.size());
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      got = got_q.pop_front();
      check_res(got, exp_q.pop_front());
      n_results++;
    end
    if (got_q.size() > 0) begin
      n_results += got_q.size();  // Extra results still count as arrivals
      got = got_q.pop_front();
      errors++;
      $display("An extra result from pc %h arrived with nothing outstanding", got.pc);
      got_q.delete();
    end
    exp_q.delete();
  endtask

  task automatic load_reg(input reg_idx_t rd, input xword_t val);
    xword_t upper;
    upper = val + 32'h800;  // ADDI sign-extends the low 12 bits
    send_instr(enc_u(7'b0110111, upper[31:12], rd));
    send_instr(enc_i(val[11:0], 3'd0, rd, rd));
  endtask

  task automatic test_alu_ops();
    logic [11:0] imm;
    for (int round = 0; round < 4; round++) begin
      load_reg(5'd1, $urandom());
      load_reg(5'd2, $urandom());
      for (int f3 = 0; f3 < 8; f3++) begin
        send_instr(enc_r(7'h00, 3'(f3), 5'd3, 5'd1, 5'd2));
        imm = 12'($urandom());
        if (f3 == 1 || f3 == 5) begin
          imm = {7'h00, imm[4:0]};
        end
        send_instr(enc_i(imm, 3'(f3), 5'd4, 5'd1));
      end
      send_instr(enc_r(7'h20, 3'd0, 5'd3, 5'd1, 5'd2));  // SUB
      send_instr(enc_r(7'h20, 3'd5, 5'd3, 5'd1, 5'd2));  // SRA
      imm = {7'h20, 5'($urandom())};
      send_instr(enc_i(imm, 3'd5, 5'd4, 5'd1));
    end
    collect_results();
  endtask

  task automatic test_mul_ops();
    xword_t a_vals [5] = '{32'hffff_fffd, 32'h8000_0000, 32'h8000_0000, 32'h0,
                           32'h7fff_ffff};
    xword_t b_vals [5] = '{32'hffff_fff9, 32'h8000_0000, 32'hffff_ffff, 32'h1234_5678,
                           32'hffff_ffff};
    for (int i = 0; i < 5; i++) begin
      load_reg(5'd5, a_vals[i]);
      load_reg(5'd6, b_vals[i]);
      for (int f3 = 0; f3 < 4; f3++) begin
        send_instr(enc_r(7'h01, 3'(f3), 5'd7, 5'd5, 5'd6));
      end
      send_instr(enc_r(7'h01, 3'd2, 5'd7, 5'd6, 5'd5));  // MULHSU with the factors swapped
    end
    collect_results();
  endtask

  task automatic test_upper_link();
    next_pc = $urandom() & 32'hffff_fffc;
    for (int i = 0; i < 3; i++) begin
      send_instr(enc_u(7'b0010111, 20'($urandom()), 5'd8));
      send_instr(enc_jal({20'($urandom()), 1'b0}, 5'd9));
    end
    send_instr(enc_jal(21'h00_0010, 5'd0));
    collect_results();
  endtask

  task automatic test_dependency();
    send_instr(enc_i(12'd5, 3'd0, 5'd1, 5'd0));
    send_instr(enc_r(7'h00, 3'd0, 5'd2, 5'd1, 5'd1));  // Needs x1 from the line above
    send_instr(enc_i(12'hff9, 3'd0, 5'd1, 5'd1));
    send_instr(enc_r(7'h20, 3'd0, 5'd3, 5'd2, 5'd1));
    for (int i = 0; i < 6; i++) begin
      send_instr(enc_i(12'd3, 3'd0, 5'd12, 5'd12));
    end
    send_instr(enc_i(12'd99, 3'd0, 5'd0, 5'd0));
    send_instr(enc_r(7'h00, 3'd6, 5'd13, 5'd0, 5'd12));
    send_instr(enc_i(12'd0, 3'd0, 5'd0, 5'd0));
    collect_results();
  endtask

  task automatic test_backpressure();
    reg_idx_t rs;
    int       start;
    start = n_results;
    hold_len = $urandom_range(8, 40);
    bp_mode = 1'b1;
    for (int i = 0; i < 16; i++) begin
      rs = (i < 8) ? 5'd0 : 5'(16 + (i + 4) % 8);  // First eight are independent and fill the FIFO
      send_instr(enc_i(12'($urandom()), (i % 2 == 0) ? 3'd0 : 3'd4, 5'(16 + i % 8), rs));
    end
    collect_results();
    check_count(n_results - start, 16);
    bp_mode = 1'b0;
  endtask

  task automatic test_illegal();
    int start;
    load_reg(5'd5, 32'h1357_9bdf);
    collect_results();
    start = n_results;
    send_instr({7'h00, 5'd2, 5'd1, 3'd0, 5'd5, 7'b1111111});
    collect_results();
    check_count(n_results - start, 1);
    send_instr(enc_i(12'd0, 3'd0, 5'd0, 5'd5));
    send_instr(enc_i(12'd0, 3'd0, 5'd0, 5'd1));
    send_instr(enc_i(12'd0, 3'd0, 5'd0, 5'd2));
    collect_results();
  endtask

  initial begin
    held = 0;
    res_ready_i = 1'b1;
    forever begin
      @(posedge clk);
      #0.5;
      if (!bp_mode) begin
        held = 0;
        res_ready_i = 1'b1;
      end else if (held < hold_len) begin
        held++;
        res_ready_i = 1'b0;
      end else begin
        res_ready_i = 1'($urandom_range(0, 1));
      end
    end
  end

  // Transfers are recorded half a cycle before the edge that completes them
  initial begin
    forever begin
      @(negedge clk);
      if (!reset_i && res_valid_o && res_ready_i) begin
        got_q.push_back(res_o);
      end
    end
  end

  initial begin
    void'($urandom(32'he7f2_f83a));
    errors = 0;
    timeouts = 0;
    n_results = 0;
    n_sent = 0;
    bp_mode = 1'b0;
    hold_len = 0;
    next_pc = 32'h0000_1000;
    reset_i = 1'b1;
    instr_valid_i = 1'b0;
    instr_i = '0;
    pc_i = '0;
    for (int i = 0; i < `RV_NREGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk);
    #0.5;
    reset_i = 1'b0;
    test_alu_ops();
    test_mul_ops();
    test_upper_link();
    test_dependency();
    test_backpressure();
    test_illegal();
    repeat (20) @(posedge clk);
    collect_results();
    check_count(n_results, n_sent);
    $display("Closing summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/rv_ex_props.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module rv_ex_props (
  input logic                  clk,
  input logic                  reset_i,
  input logic                  instr_ready_i,
  input logic                  res_valid_i,
  input rv_ex_pkg::ex_res_t    res_i,
  input logic                  res_ready_i,
  input logic                  wb_we_i,
  input rv_ex_pkg::reg_idx_t   wb_rd_i,
  input logic [`RV_NREGS-1:0]  pending_i
);

  // A stalled result keeps both its valid and its payload
  res_hold_a: assert property (@(posedge clk) disable iff (reset_i)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
  else $error("res_o changed or dropped while res_ready_i was low");

  ready_after_reset_a: assert property (@(posedge clk)
    $fell(reset_i) |-> !instr_ready_i)
  else $error("instr_ready_o was high in the first cycle after reset");

  // Every writeback retires a destination that the decoder still holds as pending
  wb_rd_a: assert property (@(posedge clk) disable iff (reset_i)
    wb_we_i |-> wb_rd_i != '0 && pending_i[wb_rd_i])
  else $error("writeback to x0 or to a register with no pending write");

endmodule

bind rv_ex_top rv_ex_props u_props (
  .clk           (clk),
  .reset_i       (reset_i),
  .instr_ready_i (instr_ready_o),
  .res_valid_i   (res_valid_o),
  .res_i         (res_o),
  .res_ready_i   (res_ready_i),
  .wb_we_i       (wb_we),
  .wb_rd_i       (wb_rd),
  .pending_i     (u_dec.pending_q)
);

`default_nettype wire

/* rtl/rv_ex_top.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module rv_ex_top (
  input  logic               clk,
  input  logic               reset_i,
  input  logic               instr_valid_i,
  input  rv_ex_pkg::xword_t  instr_i,
  input  rv_ex_pkg::xword_t  pc_i,
  output logic               instr_ready_o,
  output logic               res_valid_o,
  output rv_ex_pkg::ex_res_t res_o,
  input  logic               res_ready_i
);
  import rv_ex_pkg::*;

  reg_idx_t rf_raddr1;
  reg_idx_t rf_raddr2;
  xword_t   rf_rdata1;
  xword_t   rf_rdata2;
  logic     dec_req_valid;
  ex_req_t  dec_req;
  logic     fifo_in_ready;
  logic     alu_req_valid;
  ex_req_t  alu_req;
  logic     alu_req_ready;
  logic     wb_we;
  reg_idx_t wb_rd;
  xword_t   wb_data;

  reg_file u_rf (
    .clk      (clk),
    .reset_i  (reset_i),
    .raddr1_i (rf_raddr1),
    .raddr2_i (rf_raddr2),
    .rdata1_o (rf_rdata1),
    .rdata2_o (rf_rdata2),
    .we_i     (wb_we),
    .waddr_i  (wb_rd),
    .wdata_i  (wb_data)
  );

  id_decode u_dec (
    .clk           (clk),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .raddr1_o      (rf_raddr1),
    .raddr2_o      (rf_raddr2),
    .rdata1_i      (rf_rdata1),
    .rdata2_i      (rf_rdata2),
    .wb_we_i       (wb_we),
    .wb_rd_i       (wb_rd),
    .req_valid_o   (dec_req_valid),
    .req_o         (dec_req),
    .req_ready_i   (fifo_in_ready)
  );

  pipe_fifo #(
    .payload_t (ex_req_t),
    .DEPTH     (`RV_FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (dec_req_valid),
    .in_data_i   (dec_req),
    .in_ready_o  (fifo_in_ready),
    .out_valid_o (alu_req_valid),
    .out_data_o  (alu_req),
    .out_ready_i (alu_req_ready)
  );

  ex_alu u_alu (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_valid_i (alu_req_valid),
    .req_i       (alu_req),
    .req_ready_o (alu_req_ready),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_ready_i (res_ready_i),
    .wb_we_o     (wb_we),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data)
  );

endmodule

`default_nettype wire

/* rtl/ex_alu.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module ex_alu (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                req_valid_i,
  input  rv_ex_pkg::ex_req_t  req_i,
  output logic                req_ready_o,
  output logic                res_valid_o,
  output rv_ex_pkg::ex_res_t  res_o,
  input  logic                res_ready_i,
  output logic                wb_we_o,
  output rv_ex_pkg::reg_idx_t wb_rd_o,
  output rv_ex_pkg::xword_t   wb_data_o
);
  import rv_ex_pkg::*;

  localparam int XLEN       = `RV_XLEN;
  localparam bit MUL_ENABLE = `RV_MUL_ENABLE;

  xword_t            op_a;
  xword_t            op_b;
  logic [4:0]        shamt;
  logic              mul_a_signed;
  logic              mul_b_signed;
  logic [XLEN:0]     mul_a;
  logic [XLEN:0]     mul_b;
  logic [2*XLEN-1:0] mul_prod;
  xword_t            alu_data;
  logic              accept;
  logic              res_valid_q;
  ex_res_t           res_q;

  assign op_a  = (req_i.src1 == SRC1_PC) ? req_i.pc : req_i.rs1_val;
  assign op_b  = (req_i.src2 == SRC2_IMM) ? req_i.imm : req_i.rs2_val;
  assign shamt = op_b[4:0];

  // One extra bit per operand lets a single signed multiply cover all four variants
  assign mul_a_signed = (req_i.op == ALU_MULH) || (req_i.op == ALU_MULHSU);
  assign mul_b_signed = (req_i.op == ALU_MULH);
  assign mul_a = {mul_a_signed & op_a[XLEN-1], op_a};
  assign mul_b = {mul_b_signed & op_b[XLEN-1], op_b};

  generate
    if (MUL_ENABLE) begin : g_mul
      logic signed [2*XLEN+1:0] mul_full;
      assign mul_full = $signed(mul_a) * $signed(mul_b);
      assign mul_prod = mul_full[2*XLEN-1:0];
    end else begin : g_no_mul
      assign mul_prod = '0;  // Decoder already flags these as illegal
    end
  endgenerate

  always_comb begin
    case (req_i.op)
      ALU_ADD:    alu_data = op_a + op_b;
      ALU_SUB:    alu_data = op_a - op_b;
      ALU_SLL:    alu_data = op_a << shamt;
      ALU_SRL:    alu_data = op_a >> shamt;
      ALU_SRA:    alu_data = $signed(op_a) >>> shamt;
      ALU_SLT:    alu_data = xword_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:   alu_data = xword_t'(op_a < op_b);
      ALU_OR:     alu_data = op_a | op_b;
      ALU_XOR:    alu_data = op_a ^ op_b;
      ALU_AND:    alu_data = op_a & op_b;
      ALU_MUL:    alu_data = mul_prod[XLEN-1:0];
      ALU_MULH,
      ALU_MULHSU,
      ALU_MULHU:  alu_data = mul_prod[2*XLEN-1:XLEN];
      ALU_LINK:   alu_data = req_i.link_addr;
      ALU_PASS:   alu_data = op_b;  // LUI immediate
      default:    alu_data = '0;
    endcase
  end

  // Output register takes a new result when empty or when the current one leaves
  assign req_ready_o = !res_valid_q || res_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      res_valid_q <= 1'b0;
    end else if (accept) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_q.pc      <= req_i.pc;
      res_q.rd      <= req_i.rd;
      res_q.data    <= alu_data;
      res_q.illegal <= req_i.illegal;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

  assign wb_we_o   = res_valid_q && res_ready_i && !res_q.illegal && (res_q.rd != '0);
  assign wb_rd_o   = res_q.rd;
  assign wb_data_o = res_q.data;

endmodule

`default_nettype wire

/* rtl/pipe_fifo.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module pipe_fifo #(
  parameter type payload_t = logic [`RV_XLEN-1:0],
  parameter int  DEPTH     = `RV_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     reset_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full        = (count_q == CNT_W'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign in_ready_o  = !full || out_ready_i;  // A full FIFO still takes a push on a pop
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;
  assign out_data_o  = mem_q[rd_ptr_q];  // Head is visible without a read strobe

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/id_decode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module id_decode (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                instr_valid_i,
  input  rv_ex_pkg::xword_t   instr_i,
  input  rv_ex_pkg::xword_t   pc_i,
  output logic                instr_ready_o,
  output rv_ex_pkg::reg_idx_t raddr1_o,
  output rv_ex_pkg::reg_idx_t raddr2_o,
  input  rv_ex_pkg::xword_t   rdata1_i,
  input  rv_ex_pkg::xword_t   rdata2_i,
  input  logic                wb_we_i,
  input  rv_ex_pkg::reg_idx_t wb_rd_i,
  output logic                req_valid_o,
  output rv_ex_pkg::ex_req_t  req_o,
  input  logic                req_ready_i
);
  import rv_ex_pkg::*;

  localparam bit MUL_ENABLE = `RV_MUL_ENABLE;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  reg_idx_t            rd;
  reg_idx_t            rs1;
  reg_idx_t            rs2;
  alu_op_e             dec_op;
  src1_e               dec_src1;
  src2_e               dec_src2;
  xword_t              dec_imm;
  logic                dec_illegal;
  logic                uses_rs1;
  logic                uses_rs2;
  logic                hazard;
  logic                out_free;
  logic                issue;
  logic                ready_q;
  logic                req_valid_q;
  ex_req_t             req_q;
  logic [`RV_NREGS-1:0] pending_q;  // One bit per destination still in flight

  function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    alu_op_of = alt ? ALU_SUB : ALU_ADD;
      3'd1:    alu_op_of = ALU_SLL;
      3'd2:    alu_op_of = ALU_SLT;
      3'd3:    alu_op_of = ALU_SLTU;
      3'd4:    alu_op_of = ALU_XOR;
      3'd5:    alu_op_of = alt ? ALU_SRA : ALU_SRL;
      3'd6:    alu_op_of = ALU_OR;
      default: alu_op_of = ALU_AND;
    endcase
  endfunction

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  always_comb begin
    dec_op      = ALU_ADD;
    dec_src1    = SRC1_REG;
    dec_src2    = SRC2_REG;
    dec_imm     = '0;
    dec_illegal = 1'b0;
    uses_rs1    = 1'b0;
    uses_rs2    = 1'b0;
    case (opcode)
      7'b0110011: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        if (funct7 == 7'b0000001) begin  // M extension, divides are not supported
          dec_illegal = !MUL_ENABLE || funct3[2];
          case (funct3[1:0])
            2'd0:    dec_op = ALU_MUL;
            2'd1:    dec_op = ALU_MULH;
            2'd2:    dec_op = ALU_MULHSU;
            default: dec_op = ALU_MULHU;
          endcase
        end else begin
          dec_op      = alu_op_of(funct3, funct7[5]);
          dec_illegal = !((funct7 == 7'b0000000) ||
                          (funct7 == 7'b0100000 && (funct3 == 3'd0 || funct3 == 3'd5)));
        end
      end
      7'b0010011: begin
        uses_rs1    = 1'b1;
        dec_src2    = SRC2_IMM;
        dec_imm     = {{20{instr_i[31]}}, instr_i[31:20]};
        dec_op      = alu_op_of(funct3, (funct3 == 3'd5) && funct7[5]);
        dec_illegal = ((funct3 == 3'd1) && (funct7 != 7'b0000000)) ||
                      ((funct3 == 3'd5) && (funct7 != 7'b0000000) && (funct7 != 7'b0100000));
      end
      7'b0110111: begin  // LUI
        dec_op   = ALU_PASS;
        dec_src2 = SRC2_IMM;
        dec_imm  = {instr_i[31:12], 12'b0};
      end
      7'b0010111: begin  // AUIPC
        dec_src1 = SRC1_PC;
        dec_src2 = SRC2_IMM;
        dec_imm  = {instr_i[31:12], 12'b0};
      end
      7'b1101111: begin
        dec_op  = ALU_LINK;  // Only the link write, the jump itself is not taken here
        dec_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  assign hazard = (uses_rs1 && pending_q[rs1]) || (uses_rs2 && pending_q[rs2]) || pending_q[rd];
  assign out_free = !req_valid_q || req_ready_i;
  assign instr_ready_o = ready_q && out_free && !hazard;
  assign issue = instr_valid_i && instr_ready_o;

  assign raddr1_o = rs1;
  assign raddr2_o = rs2;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ready_q     <= 1'b0;
      req_valid_q <= 1'b0;
      pending_q   <= '0;
    end else begin
      ready_q <= 1'b1;  // Holds ready low for the first cycle out of reset
      if (issue) begin
        req_valid_q <= 1'b1;
      end else if (req_ready_i) begin
        req_valid_q <= 1'b0;
      end
      if (wb_we_i) begin
        pending_q[wb_rd_i] <= 1'b0;
      end
      if (issue && !dec_illegal && (rd != '0)) begin
        pending_q[rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_q.pc        <= pc_i;
      req_q.op        <= dec_op;
      req_q.src1      <= dec_src1;
      req_q.src2      <= dec_src2;
      req_q.rs1_val   <= rdata1_i;
      req_q.rs2_val   <= rdata2_i;
      req_q.imm       <= dec_imm;
      req_q.link_addr <= pc_i + xword_t'(4);
      req_q.rd        <= rd;
      req_q.illegal   <= dec_illegal;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_ex_config.svh"

module reg_file (
  input  logic                clk,
  input  logic                reset_i,
  input  rv_ex_pkg::reg_idx_t raddr1_i,
  input  rv_ex_pkg::reg_idx_t raddr2_i,
  output rv_ex_pkg::xword_t   rdata1_o,
  output rv_ex_pkg::xword_t   rdata2_o,
  input  logic                we_i,
  input  rv_ex_pkg::reg_idx_t waddr_i,
  input  rv_ex_pkg::xword_t   wdata_i
);

  localparam int NREGS = `RV_NREGS;

  logic [`RV_XLEN-1:0] regs_q [NREGS];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin  // x0 is hardwired
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // No write-to-read bypass, a new value shows up the cycle after the write
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];
  assign rdata2_o = (raddr2_i == '0) ? '0 : regs_q[raddr2_i];

endmodule

`default_nettype wire

/* rtl/rv_ex_pkg.sv */
`default_nettype none
`include "rv_ex_config.svh"

package rv_ex_pkg;

  typedef logic [`RV_XLEN-1:0] xword_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_OR,
    ALU_XOR,
    ALU_AND,
    ALU_MUL,
    ALU_MULH,
    ALU_MULHSU,
    ALU_MULHU,
    ALU_LINK,  // Result is the link address
    ALU_PASS   // Result is the second operand, used by LUI
  } alu_op_e;

  typedef enum logic {SRC1_REG, SRC1_PC} src1_e;
  typedef enum logic {SRC2_REG, SRC2_IMM} src2_e;

  typedef struct packed {
    xword_t   pc;
    alu_op_e  op;
    src1_e    src1;
    src2_e    src2;
    xword_t   rs1_val;
    xword_t   rs2_val;
    xword_t   imm;
    xword_t   link_addr;
    reg_idx_t rd;
    logic     illegal;
  } ex_req_t;

  typedef struct packed {
    xword_t   pc;
    reg_idx_t rd;
    xword_t   data;
    logic     illegal;  // Set for undecodable instructions, never written back
  } ex_res_t;

endpackage

`default_nettype wire

/* rtl/rv_ex_config.svh */
`ifndef RV_EX_CONFIG_SVH
`define RV_EX_CONFIG_SVH

// Width of the integer data path and of every register
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Entries in the request FIFO between decode and execute
`define RV_FIFO_DEPTH 4

// Multiplier build switch
// With 0 the multiply instructions are decoded as illegal and their data reads as zero
`define RV_MUL_ENABLE 1

`endif
